// File: common/tcb_pkg.sv
`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // interconnect configuration
  ////////////////////////////////////////

  // number of manager ports
  localparam int unsigned PN = 3;
  // manager index width
  localparam int unsigned PL = 2;

  // manager index
  typedef logic [PL-1:0] sel_t;

  // priority order, entry 0 wins
  // manager 2 beats 0, 0 beats 1
  localparam sel_t PRI [0:PN-1] = '{2'd2, 2'd0, 2'd1};

  // read data delay after the transfer edge
  localparam int unsigned DLY = 1;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // byte address
  typedef logic [11:0] adr_t;
  // byte enables
  typedef logic [3:0] ben_t;
  // write and read data
  typedef logic [31:0] dat_t;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // region select bit, 0 memory, 1 status
  localparam int unsigned REGION_BIT = 11;

  // memory depth in words and its index width
  localparam int unsigned MEM_WORDS = 512;
  localparam int unsigned MEM_AW = $clog2(MEM_WORDS);

  // status word offsets, address bits 3:2
  localparam logic [1:0] STS_ID = 2'd0;
  localparam logic [1:0] STS_SCRATCH = 2'd1;
  localparam logic [1:0] STS_SET = 2'd2;

  // identifier register value
  localparam dat_t STATUS_ID = 32'h7cb5_0a01;

endpackage

`default_nettype wire

// File: interconnect/tcb_lib_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_lib_arbiter (
  // request valids, one per manager
  input  logic [tcb_pkg::PN-1:0] vld,
  // winning manager index
  output tcb_pkg::sel_t          sel,
  // one-hot grant
  output logic [tcb_pkg::PN-1:0] gnt
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  // valids in priority order
  logic [PN-1:0] vld_ord;
  // winning position in priority order
  sel_t          pos;

  ////////////////////////////////////////
  // priority helpers
  ////////////////////////////////////////

  // place valid of manager PRI[i] at position i
  function automatic logic [PN-1:0] reorder (input logic [PN-1:0] val);
    for (int unsigned i = 0; i < PN; i++) begin
      reorder[i] = val[PRI[i]];
    end
  endfunction

  // lowest set position wins
  // no bit set gives position 0
  function automatic sel_t encode (input logic [PN-1:0] val);
    encode = '0;
    for (int i = PN-1; i >= 0; i--) begin
      if (val[i]) begin
        encode = sel_t'(i);
      end
    end
  endfunction

  ////////////////////////////////////////
  // fixed priority arbiter
  ////////////////////////////////////////

  assign vld_ord = reorder(vld);
  assign pos     = encode(vld_ord);

  // back to manager index
  // idle bus parks on the top priority manager
  assign sel = PRI[pos];

  // grant only a manager that actually requests
  always_comb begin
    gnt      = '0;
    gnt[sel] = vld[sel];
  end

endmodule

`default_nettype wire

// File: interconnect/tcb_lib_multiplexer.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_lib_multiplexer (
  // manager side
  input  logic [tcb_pkg::PN-1:0] man_vld,
  input  logic [tcb_pkg::PN-1:0] man_wen,
  input  tcb_pkg::adr_t          man_adr [0:tcb_pkg::PN-1],
  input  tcb_pkg::ben_t          man_ben [0:tcb_pkg::PN-1],
  input  tcb_pkg::dat_t          man_wdt [0:tcb_pkg::PN-1],
  output logic [tcb_pkg::PN-1:0] man_rdy,
  // shared bus side
  output logic                   bus_vld,
  output logic                   bus_wen,
  output tcb_pkg::adr_t          bus_adr,
  output tcb_pkg::ben_t          bus_ben,
  output tcb_pkg::dat_t          bus_wdt,
  input  logic                   bus_rdy
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////

  // selected manager
  sel_t          sel;
  // one-hot grant
  logic [PN-1:0] gnt;

  tcb_lib_arbiter arbiter_i (
    .vld (man_vld),
    .sel (sel),
    .gnt (gnt)
  );

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // any request means the winner requests
  assign bus_vld = |man_vld;

  // payload of the winner
  // parks on top priority manager while idle
  assign bus_wen = man_wen[sel];
  assign bus_adr = man_adr[sel];
  assign bus_ben = man_ben[sel];
  assign bus_wdt = man_wdt[sel];

  ////////////////////////////////////////
  // ready path
  ////////////////////////////////////////

  // losers see ready low and hold their request
  // the only back-pressure in the system
  assign man_rdy = gnt & {PN{bus_rdy}};

endmodule

`default_nettype wire

// File: interconnect/tcb_lib_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_lib_decoder (
  input  logic          clk,
  input  logic          arst_n,
  // shared bus side
  input  logic          bus_vld,
  input  logic          bus_wen,
  input  tcb_pkg::adr_t bus_adr,
  input  tcb_pkg::ben_t bus_ben,
  input  tcb_pkg::dat_t bus_wdt,
  output logic          bus_rdy,
  output tcb_pkg::dat_t bus_rdt,
  // memory subordinate
  output logic          mem_vld,
  output logic          mem_wen,
  output tcb_pkg::adr_t mem_adr,
  output tcb_pkg::ben_t mem_ben,
  output tcb_pkg::dat_t mem_wdt,
  input  logic          mem_rdy,
  input  tcb_pkg::dat_t mem_rdt,
  // status subordinate
  output logic          sts_vld,
  output logic          sts_wen,
  output tcb_pkg::adr_t sts_adr,
  output tcb_pkg::ben_t sts_ben,
  output tcb_pkg::dat_t sts_wdt,
  input  logic          sts_rdy,
  input  tcb_pkg::dat_t sts_rdt
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  // region of the current request, high for status
  logic bus_sts;
  // accepted read on this edge
  logic bus_rd;
  // delayed region, one stage per response cycle
  logic [DLY-1:0] rsp_sts;

  assign bus_sts = bus_adr[REGION_BIT];

  // valid only toward the addressed subordinate
  assign mem_vld = bus_vld & ~bus_sts;
  assign sts_vld = bus_vld &  bus_sts;

  // payload goes to both, qualified by valid
  assign mem_wen = bus_wen;
  assign mem_adr = bus_adr;
  assign mem_ben = bus_ben;
  assign mem_wdt = bus_wdt;

  assign sts_wen = bus_wen;
  assign sts_adr = bus_adr;
  assign sts_ben = bus_ben;
  assign sts_wdt = bus_wdt;

  // ready from the addressed side
  assign bus_rdy = bus_sts ? sts_rdy : mem_rdy;

  ////////////////////////////////////////
  // response select
  ////////////////////////////////////////

  assign bus_rd = bus_vld & bus_rdy & ~bus_wen;

  // stage 0 captures region of each read transfer
  // and holds, so rdt stays on the last read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_sts <= '0;
    end else begin
      if (bus_rd) begin
        rsp_sts[0] <= bus_sts;
      end
      // later stages follow every cycle
      for (int unsigned i = 1; i < DLY; i++) begin
        rsp_sts[i] <= rsp_sts[i-1];
      end
    end
  end

  // next request may already sit on the bus here
  assign bus_rdt = rsp_sts[DLY-1] ? sts_rdt : mem_rdt;

endmodule

`default_nettype wire

// File: source/tcb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_mem (
  input  logic          clk,
  // subordinate port
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  output logic          rdy,
  output tcb_pkg::dat_t rdt
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // word array
  dat_t mem [0:MEM_WORDS-1];

  // word index, byte offset bits dropped
  logic [MEM_AW-1:0] idx;

  assign idx = adr[MEM_AW+1:2];

  // never stalls
  assign rdy = 1'b1;

  ////////////////////////////////////////
  // write and read
  ////////////////////////////////////////

  // only enabled bytes change
  always_ff @(posedge clk) begin
    if (vld & rdy & wen) begin
      for (int unsigned b = 0; b < $bits(ben_t); b++) begin
        if (ben[b]) begin
          mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  // word registered on each read transfer
  // holds until the next read
  always_ff @(posedge clk) begin
    if (vld & rdy & ~wen) begin
      rdt <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: source/tcb_status.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_status (
  input  logic          clk,
  input  logic          arst_n,
  // subordinate port
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  output logic          rdy,
  output tcb_pkg::dat_t rdt
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // word offset within the block
  logic [1:0] ofs;
  // byte enables widened to a bit mask
  dat_t       msk;
  // read and write scratch
  dat_t       scratch;
  // bits only ever set by writes
  dat_t       sticky;

  assign ofs = adr[3:2];
  assign rdy = 1'b1;

  always_comb begin
    for (int unsigned b = 0; b < $bits(ben_t); b++) begin
      msk[8*b +: 8] = {8{ben[b]}};
    end
  end

  // writes, identifier and offset 3 ignore them
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scratch <= '0;
      sticky  <= '0;
    end else if (vld & rdy & wen) begin
      case (ofs)
        // byte merge
        STS_SCRATCH: scratch <= (scratch & ~msk) | (wdt & msk);
        // OR in enabled bytes
        STS_SET:     sticky  <= sticky | (wdt & msk);
        default:     ;
      endcase
    end
  end

  ////////////////////////////////////////
  // read data
  ////////////////////////////////////////

  // registered, valid the cycle after the transfer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdt <= '0;
    end else if (vld & rdy & ~wen) begin
      case (ofs)
        STS_ID:      rdt <= STATUS_ID;
        STS_SCRATCH: rdt <= scratch;
        STS_SET:     rdt <= sticky;
        // unused offset
        default:     rdt <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/tcb_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_subsystem (
  input  logic                   clk,
  input  logic                   arst_n,
  // manager ports
  input  logic [tcb_pkg::PN-1:0] man_vld,
  input  logic [tcb_pkg::PN-1:0] man_wen,
  input  tcb_pkg::adr_t          man_adr [0:tcb_pkg::PN-1],
  input  tcb_pkg::ben_t          man_ben [0:tcb_pkg::PN-1],
  input  tcb_pkg::dat_t          man_wdt [0:tcb_pkg::PN-1],
  output logic [tcb_pkg::PN-1:0] man_rdy,
  // read data shared by all managers
  output tcb_pkg::dat_t          rsp_rdt
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // shared bus
  ////////////////////////////////////////

  logic bus_vld;
  logic bus_wen;
  adr_t bus_adr;
  ben_t bus_ben;
  dat_t bus_wdt;
  logic bus_rdy;

  // memory side
  logic mem_vld;
  logic mem_wen;
  adr_t mem_adr;
  ben_t mem_ben;
  dat_t mem_wdt;
  logic mem_rdy;
  dat_t mem_rdt;

  // status side
  logic sts_vld;
  logic sts_wen;
  adr_t sts_adr;
  ben_t sts_ben;
  dat_t sts_wdt;
  logic sts_rdy;
  dat_t sts_rdt;

  // managers onto one bus
  tcb_lib_multiplexer multiplexer_i (
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_ben (bus_ben),
    .bus_wdt (bus_wdt),
    .bus_rdy (bus_rdy)
  );

  // bus split by region, read data straight out
  tcb_lib_decoder decoder_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_ben (bus_ben),
    .bus_wdt (bus_wdt),
    .bus_rdy (bus_rdy),
    .bus_rdt (rsp_rdt),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .sts_vld (sts_vld),
    .sts_wen (sts_wen),
    .sts_adr (sts_adr),
    .sts_ben (sts_ben),
    .sts_wdt (sts_wdt),
    .sts_rdy (sts_rdy),
    .sts_rdt (sts_rdt)
  );

  ////////////////////////////////////////
  // subordinates
  ////////////////////////////////////////

  tcb_mem mem_i (
    .clk (clk),
    .vld (mem_vld),
    .wen (mem_wen),
    .adr (mem_adr),
    .ben (mem_ben),
    .wdt (mem_wdt),
    .rdy (mem_rdy),
    .rdt (mem_rdt)
  );

  tcb_status status_i (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (sts_vld),
    .wen    (sts_wen),
    .adr    (sts_adr),
    .ben    (sts_ben),
    .wdt    (sts_wdt),
    .rdy    (sts_rdy),
    .rdt    (sts_rdt)
  );

endmodule

`default_nettype wire

// File: bench/tcb_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_subsystem_tb;

  import tcb_pkg::*;

  ////////////////////////////////////////
  // bench constants
  ////////////////////////////////////////

  localparam time PERIOD = 40ns;
  // input drive delay after the rising edge
  localparam time DRV = 5ns;
  // cycles allowed to empty the bus
  localparam int DRAIN_MAX = 64;

  // traffic shapes
  localparam int MODE_MIX = 0;
  localparam int MODE_MEM = 1;
  localparam int MODE_STS = 2;
  localparam int MODE_PIPE = 3;

  // grant order with the winner first
  localparam int ORDER [0:2] = '{2, 0, 1};

  ////////////////////////////////////////
  // DUT
  ////////////////////////////////////////

  logic          clk = 1'b0;
  logic          arst_n;
  logic [PN-1:0] man_vld;
  logic [PN-1:0] man_wen;
  adr_t          man_adr [0:PN-1];
  ben_t          man_ben [0:PN-1];
  dat_t          man_wdt [0:PN-1];
  logic [PN-1:0] man_rdy;
  dat_t          rsp_rdt;

  tcb_subsystem tcb_subsystem_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .rsp_rdt (rsp_rdt)
  );

  always #(PERIOD/2) clk = ~clk;

  ////////////////////////////////////////
  // bench state
  ////////////////////////////////////////

  // pending request per manager
  logic [PN-1:0] act;
  logic [PN-1:0] r_wen;
  adr_t          r_adr [0:PN-1];
  ben_t          r_ben [0:PN-1];
  dat_t          r_wdt [0:PN-1];

  // traffic control
  logic          gen_on;
  logic [PN-1:0] gen_mask;
  logic          force_req;
  int            gen_mode;
  logic          pipe_region;

  // per manager counters
  int issued_cnt [0:PN-1];
  int done_cnt [0:PN-1];
  int stall_cnt [0:PN-1];

  int errors;
  int checks;
  int tests;

  // random source
  logic [31:0] lfsr;

  // reference model
  dat_t mem_m [0:MEM_WORDS-1];
  dat_t scratch_m;
  dat_t sticky_m;
  // expected rdt of reads accepted at an edge
  dat_t rd_q [$];

  ////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////

  // galois step with taps x^32 x^22 x^2 x 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s >> 1;
    if (s[0]) begin
      lfsr_step = lfsr_step ^ 32'h8020_0003;
    end
  endfunction

  // one step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // fill value where every index bit shows up
  function automatic dat_t fill_word(input logic [8:0] w);
    fill_word = {w, ~w, w[7:0], 6'h2d};
  endfunction

  function automatic dat_t byte_mask(input ben_t ben);
    for (int b = 0; b < 4; b++) begin
      byte_mask[8*b +: 8] = {8{ben[b]}};
    end
  endfunction

  task automatic model_write(input adr_t adr, input ben_t ben, input dat_t wdt);
    dat_t msk;
    msk = byte_mask(ben);
    if (!adr[11]) begin
      mem_m[adr[10:2]] = (mem_m[adr[10:2]] & ~msk) | (wdt & msk);
    end else if (adr[3:2] == 2'd1) begin
      scratch_m = (scratch_m & ~msk) | (wdt & msk);
    end else if (adr[3:2] == 2'd2) begin
      sticky_m = sticky_m | (wdt & msk);
    end
  endtask

  function automatic dat_t model_read(input adr_t adr);
    if (!adr[11]) begin
      model_read = mem_m[adr[10:2]];
    end else begin
      case (adr[3:2])
        2'd0:    model_read = STATUS_ID;
        2'd1:    model_read = scratch_m;
        2'd2:    model_read = sticky_m;
        default: model_read = '0;
      endcase
    end
  endfunction

  ////////////////////////////////////////
  // manager side
  ////////////////////////////////////////

  task automatic start_request(input int m, input logic wen, input adr_t adr,
                               input ben_t ben, input dat_t wdt);
    act[m]   = 1'b1;
    r_wen[m] = wen;
    r_adr[m] = adr;
    r_ben[m] = ben;
    r_wdt[m] = wdt;
    issued_cnt[m]++;
  endtask

  // new requests for idle managers
  task automatic new_requests();
    logic [31:0] v;
    logic        wen;
    logic        reg_sts;
    logic [8:0]  word;
    ben_t        ben;
    for (int m = 0; m < PN; m++) begin
      if (gen_on && gen_mask[m] && !act[m]) begin
        draw(2, v);
        if (force_req || v[1:0] != 2'b00) begin
          draw(1, v);
          wen = v[0];
          if (gen_mode == MODE_PIPE) begin
            // reads only with the region flipping each transfer
            wen         = 1'b0;
            reg_sts     = pipe_region;
            pipe_region = ~pipe_region;
          end else if (gen_mode == MODE_MEM) begin
            reg_sts = 1'b0;
          end else if (gen_mode == MODE_STS) begin
            reg_sts = 1'b1;
          end else begin
            draw(1, v);
            reg_sts = v[0];
          end
          draw(9, v);
          word = v[8:0];
          // narrow window so reads hit recent writes
          if (gen_mode == MODE_MEM) begin
            word[8:5] = '0;
          end
          draw(4, v);
          ben = v[3:0];
          draw(32, v);
          start_request(m, wen, {reg_sts, word, 2'b00}, ben, v);
        end
      end
    end
  endtask

  // ready pulses seen at each edge
  // one per completed request
  always @(posedge clk) begin
    for (int m = 0; m < PN; m++) begin
      if (man_rdy[m]) begin
        done_cnt[m]++;
      end
    end
  end

  ////////////////////////////////////////
  // one bus cycle
  ////////////////////////////////////////

  task automatic cycle();
    logic [PN-1:0] exp_rdy;
    logic [PN-1:0] rdy_s;
    dat_t          exp_rdt;
    new_requests();
    man_vld = act;
    man_wen = r_wen;
    for (int m = 0; m < PN; m++) begin
      man_adr[m] = r_adr[m];
      man_ben[m] = r_ben[m];
      man_wdt[m] = r_wdt[m];
    end
    // outputs settled mid cycle
    @(negedge clk);
    // data of the read from the last edge
    if (rd_q.size() > 0) begin
      exp_rdt = rd_q.pop_front();
      checks++;
      if (rsp_rdt !== exp_rdt) begin
        $display("ERR %0t rsp_rdt expected %h actual %h", $time, exp_rdt, rsp_rdt);
        errors++;
      end
    end
    // first requester in grant order
    exp_rdy = '0;
    for (int i = 0; i < PN; i++) begin
      if (exp_rdy == '0 && act[ORDER[i]]) begin
        exp_rdy[ORDER[i]] = 1'b1;
      end
    end
    rdy_s = man_rdy;
    checks++;
    if (rdy_s !== exp_rdy) begin
      $display("ERR %0t man_rdy expected %b actual %b", $time, exp_rdy, rdy_s);
      errors++;
    end
    // transfers that happen at the coming edge
    for (int m = 0; m < PN; m++) begin
      if (act[m] && rdy_s[m]) begin
        if (r_wen[m]) begin
          model_write(r_adr[m], r_ben[m], r_wdt[m]);
        end else begin
          rd_q.push_back(model_read(r_adr[m]));
        end
        act[m] = 1'b0;
      end else if (act[m]) begin
        stall_cnt[m]++;
      end
    end
    @(posedge clk);
    #(DRV);
  endtask

  // run until no request or read is left
  task automatic drain();
    int n;
    n = 0;
    while ((act != '0 || rd_q.size() > 0) && n < DRAIN_MAX) begin
      cycle();
      n++;
    end
    if (act != '0 || rd_q.size() > 0) begin
      $display("timeout: transfers still pending after %0d cycles", n);
      errors++;
      act = '0;
      rd_q.delete();
    end
  endtask

  ////////////////////////////////////////
  // test framing
  ////////////////////////////////////////

  task automatic begin_test();
    for (int m = 0; m < PN; m++) begin
      issued_cnt[m] = 0;
      done_cnt[m]   = 0;
      stall_cnt[m]  = 0;
    end
  endtask

  // each request completed exactly once
  task automatic end_test(input string name, input int e0);
    for (int m = 0; m < PN; m++) begin
      checks++;
      if (done_cnt[m] != issued_cnt[m]) begin
        $display("ERR %0t done_cnt[%0d] expected %0d actual %0d",
                 $time, m, issued_cnt[m], done_cnt[m]);
        errors++;
      end
    end
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - e0);
  endtask

  task automatic run_random(input string name, input int n, input int mode,
                            input logic [PN-1:0] mask, input logic all_req);
    int e0;
    e0 = errors;
    begin_test();
    gen_mode  = mode;
    gen_mask  = mask;
    force_req = all_req;
    gen_on    = 1'b1;
    repeat (n) begin
      cycle();
    end
    gen_on = 1'b0;
    drain();
    // low priority manager must have waited
    if (all_req && mask[1]) begin
      checks++;
      if (stall_cnt[1] == 0) begin
        $display("manager 1 was never held off under full load");
        errors++;
      end
    end
    end_test(name, e0);
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    int   e0;
    logic [8:0] wi;
    arst_n      = 1'b0;
    man_vld     = '0;
    man_wen     = '0;
    act         = '0;
    r_wen       = '0;
    gen_on      = 1'b0;
    gen_mask    = '0;
    force_req   = 1'b0;
    gen_mode    = MODE_MIX;
    pipe_region = 1'b0;
    lfsr        = 32'd87;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    scratch_m   = '0;
    sticky_m    = '0;
    for (int m = 0; m < PN; m++) begin
      man_adr[m] = '0;
      man_ben[m] = '0;
      man_wdt[m] = '0;
      r_adr[m]   = '0;
      r_ben[m]   = '0;
      r_wdt[m]   = '0;
    end
    repeat (2) @(posedge clk);
    #(DRV);
    arst_n = 1'b1;

    // idle bus then identifier read
    e0 = errors;
    begin_test();
    repeat (3) begin
      cycle();
    end
    start_request(0, 1'b0, 12'h800, 4'hf, '0);
    drain();
    end_test("reset", e0);

    // known contents in every memory word
    e0 = errors;
    begin_test();
    for (int w = 0; w < MEM_WORDS; w++) begin
      wi = 9'(w);
      start_request(1, 1'b1, {1'b0, wi, 2'b00}, 4'hf, fill_word(wi));
      drain();
    end
    end_test("fill", e0);

    run_random("priority", 300, MODE_MIX, 3'b111, 1'b0);
    run_random("backpressure", 200, MODE_MIX, 3'b111, 1'b1);
    run_random("memory", 300, MODE_MEM, 3'b111, 1'b0);
    run_random("status", 300, MODE_STS, 3'b111, 1'b0);
    run_random("pipeline", 100, MODE_PIPE, 3'b100, 1'b1);

    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tcb_subsystem.f
common/tcb_pkg.sv
interconnect/tcb_lib_arbiter.sv
interconnect/tcb_lib_multiplexer.sv
interconnect/tcb_lib_decoder.sv
source/tcb_mem.sv
source/tcb_status.sv
source/tcb_subsystem.sv
bench/tcb_subsystem_tb.sv

// File: Makefile
TOOL       := verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tcb_subsystem_tb
RTL_TOP    := tcb_subsystem
FLIST      := tcb_subsystem.f
OBJ        := obj_dir
LOG        := sim.log
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
